/* common/operand_fetch_pkg.sv */
package operand_fetch_pkg;

	// ########################################
	// widths and sizes
	// ########################################

	localparam int data_width = 16;
	localparam int n_channels = 16;
	localparam int pending_width = 4;
	localparam int commit_id_width = 6;
	localparam int n_operands = 3; // a, b, c

	typedef logic signed [data_width - 1 : 0] data_t;
	typedef logic [$clog2(n_channels) - 1 : 0] chan_addr_t;

	// source codes when is_reg is set
	localparam logic [3 : 0] src_register_0 = 4'd0;
	localparam logic [3 : 0] src_register_1 = 4'd1;
	localparam logic [3 : 0] src_const_half = 4'd3;
	localparam logic [3 : 0] src_const_full = 4'd4;

	localparam data_t const_half = {2'b01, {(data_width - 2){1'b0}}};
	localparam data_t const_full = {1'b1, {(data_width - 1){1'b0}}};

	// ########################################
	// structs
	// ########################################

	typedef struct packed {
		logic [3 : 0] index; // channel number or source code
		logic is_reg;
		logic needed;
	} operand_src_t;

	typedef struct packed {
		logic [4 : 0] operation;
		chan_addr_t dest;
		logic writes_channel;
		operand_src_t [n_operands - 1 : 0] src;
		data_t register_0;
		data_t register_1;
	} instr_t;

	// args[k] holds a value once substage k has passed
	typedef struct packed {
		instr_t instr;
		data_t [n_operands - 1 : 0] args;
	} fetch_item_t;

	typedef struct packed {
		logic [4 : 0] operation;
		chan_addr_t dest;
		logic writes_channel;
		data_t [n_operands - 1 : 0] args;
		logic [commit_id_width - 1 : 0] commit_id;
	} fetched_t;

	typedef struct packed {
		logic enable;
		chan_addr_t addr;
		data_t value;
	} channel_write_t;

endpackage

/* verilog/skid_buffer.sv */
`timescale 1ns/1ps

module skid_buffer #(
	parameter type payload_t = logic
) (
	input logic clk,
	input logic reset,

	input logic in_valid,
	output logic in_ready,
	input payload_t in_payload,

	output logic out_valid,
	input logic out_ready,
	output payload_t out_payload
);

	logic skid_valid;
	payload_t skid_payload; // catches the item in flight when out_ready fell

	logic take_in;
	logic out_free;

	assign take_in = in_valid & in_ready;
	assign out_free = ~out_valid | out_ready;

	always_ff @(posedge clk) begin
		if (reset) begin
			out_valid <= 1'b0;
			skid_valid <= 1'b0;
			in_ready <= 1'b1;
		end else if (out_free) begin
			if (skid_valid) begin
				out_valid <= 1'b1; // drain skid entry first
				skid_valid <= 1'b0;
				in_ready <= 1'b1;
			end else begin
				out_valid <= take_in;
			end
		end else if (take_in) begin
			skid_valid <= 1'b1;
			in_ready <= 1'b0; // both entries full
		end
	end

	always_ff @(posedge clk) begin
		if (out_free) begin
			if (skid_valid)
				out_payload <= skid_payload;
			else if (take_in)
				out_payload <= in_payload;
		end else if (take_in) begin
			skid_payload <= in_payload;
		end
	end

endmodule

/* operand_fetch/channel_scoreboard.sv */
`timescale 1ns/1ps

module channel_scoreboard
	import operand_fetch_pkg::*;
(
	input logic clk,
	input logic reset,

	input channel_write_t channel_write,

	input logic issue, // a writer left this substage
	input chan_addr_t issue_dest,

	input chan_addr_t read_addr,
	output data_t read_value,
	output logic read_ready
);

	data_t values [n_channels];
	logic [pending_width - 1 : 0] pending [n_channels];

	logic [n_channels - 1 : 0] inc;
	logic [n_channels - 1 : 0] dec;
	logic write_hit;
	logic forward;

	// per channel count changes
	always_comb begin
		for (int i = 0; i < n_channels; i++) begin
			inc[i] = issue && (issue_dest == chan_addr_t'(i));
			dec[i] = channel_write.enable && (channel_write.addr == chan_addr_t'(i))
				&& (pending[i] != '0); // stray write leaves count at 0
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < n_channels; i++) begin
				values[i] <= '0;
				pending[i] <= '0;
			end
		end else begin
			if (channel_write.enable)
				values[channel_write.addr] <= channel_write.value;

			for (int i = 0; i < n_channels; i++) begin
				case ({inc[i], dec[i]})
					2'b10: pending[i] <= pending[i] + 1'b1;
					2'b01: pending[i] <= pending[i] - 1'b1;
					default: pending[i] <= pending[i]; // both or neither
				endcase
			end
		end
	end

	// ########################################
	// operand read
	// ########################################

	assign write_hit = channel_write.enable && (channel_write.addr == read_addr);

	// last outstanding write lands right now
	assign forward = write_hit && (pending[read_addr] == pending_width'(1));

	assign read_ready = (pending[read_addr] == '0) || forward;
	assign read_value = forward ? channel_write.value : values[read_addr];

endmodule

/* operand_fetch/fetch_substage.sv */
`timescale 1ns/1ps

module fetch_substage
	import operand_fetch_pkg::*;
#(
	parameter int operand_index = 0
) (
	input logic clk,
	input logic reset,

	input logic in_valid,
	output logic in_ready,
	input fetch_item_t in_item,

	output logic out_valid,
	input logic out_ready,
	output fetch_item_t out_item,

	input channel_write_t channel_write
);

	logic busy;
	fetch_item_t held_item; // item waiting on its channel
	fetch_item_t live_item;
	fetch_item_t resolved_item;

	operand_src_t src;
	data_t operand;
	logic operand_ready;

	data_t read_value;
	logic read_ready;

	logic take_in;
	logic new_ok;
	logic held_ok;
	logic load_out;
	logic issue;

	assign in_ready = ~busy & (~out_valid | out_ready);
	assign take_in = in_valid & in_ready;

	assign live_item = busy ? held_item : in_item;
	assign src = live_item.instr.src[operand_index];

	// ########################################
	// operand resolve
	// ########################################

	always_comb begin
		operand = '0;
		operand_ready = 1'b1;
		if (src.needed) begin
			if (src.is_reg) begin
				case (src.index)
					src_register_0: operand = live_item.instr.register_0;
					src_register_1: operand = live_item.instr.register_1;
					src_const_half: operand = const_half;
					src_const_full: operand = const_full;
					default: operand = '0;
				endcase
			end else begin
				operand = read_value;
				operand_ready = read_ready; // stall on pending channel write
			end
		end
	end

	always_comb begin
		resolved_item = live_item;
		resolved_item.args[operand_index] = operand;
	end

	channel_scoreboard u_scoreboard (
		.clk(clk),
		.reset(reset),
		.channel_write(channel_write),
		.issue(issue),
		.issue_dest(live_item.instr.dest),
		.read_addr(src.index),
		.read_value(read_value),
		.read_ready(read_ready)
	);

	// ########################################
	// control
	// ########################################

	assign new_ok = ~busy & take_in & operand_ready;
	assign held_ok = busy & operand_ready & (~out_valid | out_ready);
	assign load_out = new_ok | held_ok;

	// writer counted as it is registered, so the next item already sees it
	assign issue = load_out & live_item.instr.writes_channel;

	always_ff @(posedge clk) begin
		if (reset) begin
			busy <= 1'b0;
			out_valid <= 1'b0;
		end else begin
			if (load_out)
				out_valid <= 1'b1;
			else if (out_ready)
				out_valid <= 1'b0;

			if (take_in & ~operand_ready)
				busy <= 1'b1;
			else if (held_ok)
				busy <= 1'b0; // retried and resolved
		end
	end

	always_ff @(posedge clk) begin
		if (take_in & ~operand_ready)
			held_item <= in_item;
		if (load_out)
			out_item <= resolved_item;
	end

endmodule

/* operand_fetch/operand_fetch_stage.sv */
`timescale 1ns/1ps

module operand_fetch_stage
	import operand_fetch_pkg::*;
(
	input logic clk,
	input logic reset,

	input logic in_valid,
	output logic in_ready,
	input instr_t instr,

	output logic out_valid,
	input logic out_ready,
	output fetched_t result,

	input channel_write_t channel_write
);

	// chain slot k feeds substage k, the last slot feeds the skid buffer
	fetch_item_t items [n_operands + 1];
	logic valid [n_operands + 1];
	logic ready [n_operands + 1];

	logic [commit_id_width - 1 : 0] commit_count;
	logic handoff;
	fetched_t skid_in;

	assign items[0] = '{instr: instr, args: '0};
	assign valid[0] = in_valid;
	assign in_ready = ready[0];

	// ########################################
	// substages a, b, c
	// ########################################

	for (genvar k = 0; k < n_operands; k++) begin : g_fetch
		fetch_substage #(.operand_index(k)) u_substage (
			.clk(clk),
			.reset(reset),
			.in_valid(valid[k]),
			.in_ready(ready[k]),
			.in_item(items[k]),
			.out_valid(valid[k + 1]),
			.out_ready(ready[k + 1]),
			.out_item(items[k + 1]),
			.channel_write(channel_write)
		);
	end

	// ########################################
	// commit tag and output
	// ########################################

	assign handoff = valid[n_operands] & ready[n_operands];

	always_ff @(posedge clk) begin
		if (reset)
			commit_count <= '0;
		else if (handoff && items[n_operands].instr.writes_channel)
			commit_count <= commit_count + 1'b1; // only writers advance it
	end

	always_comb begin
		skid_in.operation = items[n_operands].instr.operation;
		skid_in.dest = items[n_operands].instr.dest;
		skid_in.writes_channel = items[n_operands].instr.writes_channel;
		skid_in.args = items[n_operands].args;
		skid_in.commit_id = commit_count;
	end

	skid_buffer #(.payload_t(fetched_t)) u_skid (
		.clk(clk),
		.reset(reset),
		.in_valid(valid[n_operands]),
		.in_ready(ready[n_operands]),
		.in_payload(skid_in),
		.out_valid(out_valid),
		.out_ready(out_ready),
		.out_payload(result)
	);

endmodule

/* sim/tb_clock.sv */
`timescale 1ns/1ps

module tb_clock (
	output logic clk,
	output logic reset
);

	localparam int half_period = 5; // 10 ns clock
	localparam int reset_cycles = 10;

	initial begin
		clk = 1'b0;
		forever #(half_period) clk = ~clk;
	end

	initial begin
		reset = 1'b1;
		repeat (reset_cycles) @(posedge clk);
		@(negedge clk);
		reset = 1'b0; // released away from the active edge
	end

endmodule

/* sim/operand_fetch_chk.sv */
`timescale 1ns/1ps

module operand_fetch_chk
	import operand_fetch_pkg::*;
(
	input logic clk,
	input logic reset,
	input logic out_valid,
	input logic out_ready,
	input fetched_t result
);

	reset_clears_valid: assert property (@(posedge clk) reset |=> !out_valid)
		else $error("out_valid high in the cycle after reset");

	// a stalled result must not move
	result_held: assert property (@(posedge clk) disable iff (reset)
		out_valid && !out_ready |=> $stable(result))
		else $error("result changed while out_ready was low");

	valid_held: assert property (@(posedge clk) disable iff (reset)
		out_valid && !out_ready |=> out_valid)
		else $error("out_valid dropped without a transfer");

endmodule

/* sim/operand_fetch_tb.sv */
`timescale 1ns/1ps

module operand_fetch_tb
	import operand_fetch_pkg::*;
();

	localparam int timeout_cycles = 500;

	logic clk;
	logic reset;
	logic in_valid;
	logic in_ready;
	instr_t instr;
	logic out_valid;
	logic out_ready;
	fetched_t result;
	channel_write_t channel_write;

	int seed;
	int cycle = 0;
	bit random_ready; // out_ready toggles randomly when set
	bit saw_stall;
	int writers_seen;
	data_t chan_model [n_channels];
	fetched_t got_q [$];
	fetched_t exp_q [$];
	int accept_cycles [$];
	int done_cycles [$];

	tb_clock u_clock (.clk(clk), .reset(reset));

	operand_fetch_stage uut (
		.clk(clk),
		.reset(reset),
		.in_valid(in_valid),
		.in_ready(in_ready),
		.instr(instr),
		.out_valid(out_valid),
		.out_ready(out_ready),
		.result(result),
		.channel_write(channel_write)
	);

	bind operand_fetch_stage operand_fetch_chk u_chk (
		.clk(clk),
		.reset(reset),
		.out_valid(out_valid),
		.out_ready(out_ready),
		.result(result)
	);

	always @(posedge clk) cycle <= cycle + 1;

	// output side, a result is taken at the next rising edge
	always @(negedge clk) begin
		if (random_ready)
			out_ready = ($random(seed) & 1) != 0;
		else
			out_ready = 1'b1;
		if (!reset && out_valid && out_ready) begin
			got_q.push_back(result);
			done_cycles.push_back(cycle);
		end
	end

	// ########################################
	// helpers
	// ########################################

	task automatic stop_with_failure(input string why);
		if (why != "")
			$display("%s", why);
		$display("FAIL: see errors above");
		$fatal(1);
	endtask

	task automatic check(input string name, input logic [63:0] got, input logic [63:0] want);
		if (got !== want) begin
			$display("Error at time %0t: %s is %h, expected %h", $time, name, got, want);
			stop_with_failure("");
		end
	endtask

	function automatic operand_src_t make_src(input logic [3:0] index, input logic is_reg,
		input logic needed);
		operand_src_t s;
		s.index = index;
		s.is_reg = is_reg;
		s.needed = needed;
		return s;
	endfunction

	function automatic instr_t random_instr();
		instr_t in;
		in.operation = 5'($random(seed));
		in.dest = 4'($random(seed));
		in.writes_channel = 1'b0;
		in.register_0 = data_t'($random(seed));
		in.register_1 = data_t'($random(seed));
		for (int k = 0; k < n_operands; k++)
			in.src[k] = make_src(4'($random(seed) & 7), 1'b1, ($random(seed) & 3) != 0);
		return in;
	endfunction

	// reference operand rule
	function automatic data_t operand_of(input operand_src_t s, input instr_t in);
		data_t v;
		v = '0;
		if (s.needed && s.is_reg) begin
			case (s.index)
				4'd0: v = in.register_0;
				4'd1: v = in.register_1;
				4'd3: v = data_t'(1 << (data_width - 2));
				4'd4: v = data_t'(1 << (data_width - 1));
				default: v = '0;
			endcase
		end else if (s.needed) begin
			v = chan_model[s.index];
		end
		return v;
	endfunction

	task automatic expect_item(input instr_t in);
		fetched_t e;
		e.operation = in.operation;
		e.dest = in.dest;
		e.writes_channel = in.writes_channel;
		for (int k = 0; k < n_operands; k++)
			e.args[k] = operand_of(in.src[k], in);
		e.commit_id = commit_id_width'(writers_seen);
		if (in.writes_channel)
			writers_seen++;
		exp_q.push_back(e);
	endtask

	task automatic send(input instr_t in);
		int waited;
		waited = 0;
		in_valid = 1'b1;
		instr = in;
		while (!in_ready) begin
			saw_stall = 1'b1;
			waited++;
			if (waited > timeout_cycles)
				stop_with_failure("timeout: the stage never accepted an instruction");
			@(negedge clk);
		end
		accept_cycles.push_back(cycle);
		@(negedge clk);
		in_valid = 1'b0;
	endtask

	task automatic write_channel(input chan_addr_t addr, input data_t value);
		channel_write.enable = 1'b1;
		channel_write.addr = addr;
		channel_write.value = value;
		chan_model[addr] = value;
		@(negedge clk);
		channel_write = '0;
	endtask

	task automatic wait_results(input int n);
		int waited;
		waited = 0;
		while (got_q.size() < n) begin
			waited++;
			if (waited > timeout_cycles)
				stop_with_failure("timeout: expected results never came out of the stage");
			@(posedge clk);
		end
		@(negedge clk);
	endtask

	task automatic compare_results(input int n, input bit with_latency);
		fetched_t got;
		fetched_t want;
		int accepted;
		int delivered;
		wait_results(n);
		for (int i = 0; i < n; i++) begin
			got = got_q.pop_front();
			want = exp_q.pop_front();
			accepted = accept_cycles.pop_front();
			delivered = done_cycles.pop_front();
			check("result.operation", 64'(got.operation), 64'(want.operation));
			check("result.dest", 64'(got.dest), 64'(want.dest));
			check("result.writes_channel", 64'(got.writes_channel), 64'(want.writes_channel));
			for (int k = 0; k < n_operands; k++)
				check($sformatf("result.args[%0d]", k), 64'(got.args[k]), 64'(want.args[k]));
			check("result.commit_id", 64'(got.commit_id), 64'(want.commit_id));
			if (with_latency)
				check("latency", 64'(delivered - accepted), 64'd4);
		end
	endtask

	// ########################################
	// tests
	// ########################################

	task automatic test_commit_tags();
		instr_t in;
		logic [7:0] writer_mask;
		writer_mask = 8'b0100_1101;
		for (int i = 0; i < 8; i++) begin
			in = random_instr();
			in.dest = 4'(8 + i);
			in.writes_channel = writer_mask[i];
			expect_item(in);
			send(in);
		end
		compare_results(8, 1'b1);
		for (int i = 0; i < 8; i++)
			if (writer_mask[i])
				write_channel(4'(8 + i), data_t'($random(seed))); // settle pending counts
	endtask

	task automatic test_channel_reads();
		instr_t in;
		write_channel(4'd2, data_t'($random(seed)));
		write_channel(4'd7, data_t'($random(seed)));
		write_channel(4'd11, data_t'($random(seed)));
		in = random_instr();
		in.src[0] = make_src(4'd2, 1'b0, 1'b1);
		in.src[1] = make_src(4'd7, 1'b0, 1'b1);
		in.src[2] = make_src(4'd11, 1'b0, 1'b1);
		expect_item(in);
		send(in);
		in.src[0] = make_src(4'd11, 1'b0, 1'b1);
		in.src[1] = make_src(4'd2, 1'b0, 1'b1);
		in.src[2] = make_src(4'd1, 1'b1, 1'b1);
		expect_item(in);
		send(in);
		compare_results(2, 1'b1);
	endtask

	task automatic test_register_sources();
		instr_t in;
		for (int i = 0; i < 16; i++) begin
			in = random_instr();
			for (int k = 0; k < n_operands; k++)
				in.src[k] = make_src(4'((i + 5 * k) % 16), 1'b1, ((i + k) % 4) != 3);
			expect_item(in);
			send(in);
		end
		compare_results(16, 1'b1);
	endtask

	task automatic test_dependency_stall();
		instr_t writer;
		instr_t reader;
		data_t value;
		value = data_t'($random(seed));
		writer = random_instr();
		writer.writes_channel = 1'b1;
		writer.dest = 4'd5;
		reader = random_instr();
		reader.src[0] = make_src(4'd5, 1'b0, 1'b1);
		expect_item(writer);
		chan_model[5] = value; // reader must see the late write
		expect_item(reader);
		send(writer);
		send(reader);
		wait_results(1);
		repeat (20) @(negedge clk);
		check("results while write held back", 64'(got_q.size()), 64'd1);
		write_channel(4'd5, value);
		compare_results(2, 1'b0);
	endtask

	task automatic test_back_pressure();
		instr_t in;
		saw_stall = 1'b0;
		random_ready = 1'b1;
		for (int i = 0; i < 20; i++) begin
			in = random_instr();
			expect_item(in);
			send(in);
		end
		compare_results(20, 1'b0);
		random_ready = 1'b0;
		check("in_ready seen low", 64'(saw_stall), 64'd1);
	endtask

	initial begin
		int waited;
		seed = 45;
		in_valid = 1'b0;
		instr = '0;
		out_ready = 1'b1;
		channel_write = '0;
		random_ready = 1'b0;
		saw_stall = 1'b0;
		writers_seen = 0;
		waited = 0;
		for (int i = 0; i < n_channels; i++)
			chan_model[i] = '0;

		@(negedge clk);
		while (reset) begin
			waited++;
			if (waited > timeout_cycles)
				stop_with_failure("timeout: reset was never released");
			@(negedge clk);
		end

		test_commit_tags(); // needs the tag counter fresh from reset
		test_channel_reads();
		test_register_sources();
		test_dependency_stall();
		test_back_pressure();

		repeat (5) @(posedge clk); // a duplicated result would show up here
		check("extra results", 64'(got_q.size()), 64'd0);
		$display("PASS: all tests");
		$finish;
	end

endmodule

/* flist.f */
common/operand_fetch_pkg.sv
verilog/skid_buffer.sv
operand_fetch/channel_scoreboard.sv
operand_fetch/fetch_substage.sv
operand_fetch/operand_fetch_stage.sv
sim/tb_clock.sv
sim/operand_fetch_chk.sv
sim/operand_fetch_tb.sv

/* run.sh */
#!/bin/bash
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module operand_fetch_tb -f flist.f \
	-o operand_fetch_sim \
	&& ./obj_dir/operand_fetch_sim 2>&1 | tee sim.log
grep -qx "PASS: all tests" sim.log && echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }
